// ==== proc_defs.svh ====
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Width of data words and of one instruction
`define DATA_W 16

// Unified program and data memory, in words
`define MEM_DEPTH 256

// Architectural registers, r0 reads as zero
`define NUM_REGS 8

// First fetch address after start
`define RESET_PC 0

`endif

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // Opcodes live in the top five bits of every instruction
   typedef enum logic [4:0] {
      OP_ADD  = 5'd0,
      OP_SUB  = 5'd1,
      OP_AND  = 5'd2,
      OP_XOR  = 5'd3,
      OP_ADDI = 5'd4,
      OP_LD   = 5'd5,
      OP_ST   = 5'd6,
      OP_BEQZ = 5'd7,
      OP_HALT = 5'd8
   } opcode_e;

   // Register to register form
   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] pad;
   } r_fmt_t;

   // Immediate form, rd is the data register for ST
   typedef struct packed {
      opcode_e           opcode;
      logic [2:0]        rs;
      logic [2:0]        rd;
      logic signed [4:0] imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

   // Order matches arbitration priority, highest first
   typedef enum logic [1:0] {
      REQ_LOADER = 2'd0,
      REQ_LSU    = 2'd1,
      REQ_FETCH  = 2'd2
   } req_id_e;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_kind_e;

endpackage

`default_nettype wire

// ==== proc_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

// One requester port into the memory arbiter
interface mem_if import mem_pkg::*; ();
   localparam int ADDR_W = $clog2(`MEM_DEPTH);

   logic               req;
   mem_kind_e          kind;
   logic [ADDR_W-1:0]  addr;
   logic [`DATA_W-1:0] wdata;
   logic               gnt;
   logic               rvalid;
   logic [`DATA_W-1:0] rdata;

   modport requester (output req, kind, addr, wdata, input gnt, rvalid, rdata);
   modport arbiter (input req, kind, addr, wdata, output gnt, rvalid, rdata);
endinterface

// Instruction handoff plus the redirect path back to fetch
interface fetch_if ();
   localparam int ADDR_W = $clog2(`MEM_DEPTH);

   logic               instr_valid;
   logic               instr_ready;
   logic [`DATA_W-1:0] instr;
   logic [ADDR_W-1:0]  instr_pc;
   logic               redirect;
   logic [ADDR_W-1:0]  redirect_pc;

   modport fetch (output instr_valid, instr, instr_pc, input instr_ready, redirect, redirect_pc);
   modport core (input instr_valid, instr, instr_pc, output instr_ready, redirect, redirect_pc);
endinterface

// Core to load/store unit command
interface ls_if import mem_pkg::*; ();
   localparam int ADDR_W = $clog2(`MEM_DEPTH);

   logic               cmd_valid;
   mem_kind_e          kind;
   logic [ADDR_W-1:0]  addr;
   logic [`DATA_W-1:0] wdata;
   logic               done;
   logic [`DATA_W-1:0] rdata;

   modport core (output cmd_valid, kind, addr, wdata, input done, rdata);
   modport lsu (input cmd_valid, kind, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module mem_arbiter import mem_pkg::*; (
   input  logic                         clk,
   input  logic                         rst_n,
   mem_if.arbiter                       loader,
   mem_if.arbiter                       lsu,
   mem_if.arbiter                       fetch,
   output logic                         mem_en,
   output logic                         mem_we,
   output logic [$clog2(`MEM_DEPTH)-1:0] mem_addr,
   output logic [`DATA_W-1:0]           mem_wdata,
   input  logic [`DATA_W-1:0]           mem_rdata
);

   req_id_e   sel_id;
   logic      sel_any;
   mem_kind_e sel_kind;
   req_id_e   rd_id;
   logic      rd_pend;

   // Fixed priority: loader, then LSU, then fetch
   always_comb begin
      sel_any = 1'b1;
      sel_id  = REQ_FETCH;
      if (loader.req) begin
         sel_id = REQ_LOADER;
      end else if (lsu.req) begin
         sel_id = REQ_LSU;
      end else if (!fetch.req) begin
         sel_any = 1'b0;
      end
   end

   always_comb begin
      case (sel_id)
         REQ_LOADER: begin
            sel_kind  = loader.kind;
            mem_addr  = loader.addr;
            mem_wdata = loader.wdata;
         end
         REQ_LSU: begin
            sel_kind  = lsu.kind;
            mem_addr  = lsu.addr;
            mem_wdata = lsu.wdata;
         end
         default: begin
            sel_kind  = fetch.kind;
            mem_addr  = fetch.addr;
            mem_wdata = fetch.wdata;
         end
      endcase
   end

   assign mem_en = sel_any;
   assign mem_we = sel_any && (sel_kind == MEM_WRITE);

   assign loader.gnt = sel_any && (sel_id == REQ_LOADER);
   assign lsu.gnt    = sel_any && (sel_id == REQ_LSU);
   assign fetch.gnt  = sel_any && (sel_id == REQ_FETCH);

   // Remember who owns the read that returns next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= sel_any && (sel_kind == MEM_READ);
      end
   end

   always_ff @(posedge clk) begin
      rd_id <= sel_id;
   end

   assign loader.rvalid = rd_pend && (rd_id == REQ_LOADER);
   assign lsu.rvalid    = rd_pend && (rd_id == REQ_LSU);
   assign fetch.rvalid  = rd_pend && (rd_id == REQ_FETCH);

   assign loader.rdata = mem_rdata;
   assign lsu.rdata    = mem_rdata;
   assign fetch.rdata  = mem_rdata;

endmodule

`default_nettype wire

// ==== unified_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module unified_mem (
   input  logic                          clk,
   input  logic                          en,
   input  logic                          we,
   input  logic [$clog2(`MEM_DEPTH)-1:0] addr,
   input  logic [`DATA_W-1:0]            wdata,
   output logic [`DATA_W-1:0]            rdata
);

   // Program and data share this array
   logic [`DATA_W-1:0] mem [`MEM_DEPTH];

   // Registered read, data valid the cycle after the access
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module fetch_unit import mem_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     start,
   mem_if.requester mem,
   fetch_if.fetch   fe
);

   localparam int ADDR_W = $clog2(`MEM_DEPTH);

   logic               running;
   logic               outstanding;
   logic               discard;
   logic               buf_valid;
   logic [ADDR_W-1:0]  pc;
   logic [ADDR_W-1:0]  rd_pc;
   logic [ADDR_W-1:0]  buf_pc;
   logic [`DATA_W-1:0] buf_instr;
   logic               resp;
   logic               consume;

   // Stale data is dropped both in the redirect cycle and after it
   assign resp    = mem.rvalid && !discard && !fe.redirect;
   assign consume = fe.instr_valid && fe.instr_ready;

   // Buffer and a fresh response are never valid together
   assign fe.instr_valid = buf_valid || resp;
   assign fe.instr       = buf_valid ? buf_instr : mem.rdata;
   assign fe.instr_pc    = buf_valid ? buf_pc : rd_pc;

   assign mem.req   = running && !outstanding && (!buf_valid || consume);
   assign mem.kind  = MEM_READ;
   assign mem.addr  = pc;
   assign mem.wdata = '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         running     <= 1'b0;
         outstanding <= 1'b0;
         discard     <= 1'b0;
         buf_valid   <= 1'b0;
         pc          <= ADDR_W'(`RESET_PC);
      end else begin
         if (start) begin
            running <= 1'b1;
            pc      <= ADDR_W'(`RESET_PC);
         end
         if (mem.gnt) begin
            outstanding <= 1'b1;
            pc          <= pc + 1'b1;
         end else if (mem.rvalid) begin
            outstanding <= 1'b0;
         end
         if (fe.redirect) begin
            pc        <= fe.redirect_pc;
            buf_valid <= 1'b0;
            // A read granted now belongs to the old path
            discard   <= mem.gnt;
         end else begin
            if (mem.rvalid) begin
               discard <= 1'b0;
            end
            if (resp) begin
               buf_valid <= !consume;
            end else if (consume) begin
               buf_valid <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem.gnt) begin
         rd_pc <= pc;
      end
      if (resp) begin
         buf_instr <= mem.rdata;
         buf_pc    <= rd_pc;
      end
   end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module exec_core import isa_pkg::*, mem_pkg::*; (
   input  logic                         clk,
   input  logic                         rst_n,
   fetch_if.core                        fe,
   ls_if.core                           ls,
   output logic                         wb_valid,
   output logic [$clog2(`NUM_REGS)-1:0] wb_reg,
   output logic [`DATA_W-1:0]           wb_data,
   output logic                         halted,
   output logic                         err
);

   localparam int ADDR_W = $clog2(`MEM_DEPTH);
   localparam int REG_W  = $clog2(`NUM_REGS);

   logic [`DATA_W-1:0] regs [`NUM_REGS];
   instr_u             ins;
   logic               accept;
   logic [`DATA_W-1:0] src_a;
   logic [`DATA_W-1:0] src_b;
   logic [`DATA_W-1:0] st_data;
   logic [`DATA_W-1:0] imm_ext;
   logic [`DATA_W-1:0] ea;
   logic [`DATA_W-1:0] alu_res;
   logic [REG_W-1:0]   wr_idx;
   logic               wr_en;
   logic               take_br;
   logic               is_mem;
   logic               is_halt;
   logic               illegal;
   logic [ADDR_W-1:0]  br_target;
   logic               redir_q;
   logic [ADDR_W-1:0]  redir_pc_q;
   logic               cmd_q;
   mem_kind_e          kind_q;
   logic [ADDR_W-1:0]  addr_q;
   logic [`DATA_W-1:0] wdata_q;
   logic [REG_W-1:0]   ld_rd;

   assign ins     = fe.instr;
   // r0 stays zero since its writes are suppressed
   assign src_a   = regs[ins.r.rs];
   assign src_b   = regs[ins.r.rt];
   assign st_data = regs[ins.i.rd];
   assign imm_ext = {{(`DATA_W-5){ins.i.imm[4]}}, ins.i.imm};
   assign ea      = src_a + imm_ext;

   // Branch offset is relative to the next instruction
   assign br_target = fe.instr_pc + 1'b1 + imm_ext[ADDR_W-1:0];

   // No new instruction while halted, waiting on memory or flushing
   assign fe.instr_ready = !halted && !cmd_q && !redir_q;
   assign accept         = fe.instr_valid && fe.instr_ready;

   assign fe.redirect    = redir_q;
   assign fe.redirect_pc = redir_pc_q;
   assign ls.cmd_valid   = cmd_q;
   assign ls.kind        = kind_q;
   assign ls.addr        = addr_q;
   assign ls.wdata       = wdata_q;

   always_comb begin
      alu_res = '0;
      wr_idx  = ins.r.rd;
      wr_en   = 1'b0;
      take_br = 1'b0;
      is_mem  = 1'b0;
      is_halt = 1'b0;
      illegal = 1'b0;
      case (ins.r.opcode)
         OP_ADD: begin
            alu_res = src_a + src_b;
            wr_en   = 1'b1;
         end
         OP_SUB: begin
            alu_res = src_a - src_b;
            wr_en   = 1'b1;
         end
         OP_AND: begin
            alu_res = src_a & src_b;
            wr_en   = 1'b1;
         end
         OP_XOR: begin
            alu_res = src_a ^ src_b;
            wr_en   = 1'b1;
         end
         OP_ADDI: begin
            alu_res = ea;
            wr_idx  = ins.i.rd;
            wr_en   = 1'b1;
         end
         OP_LD, OP_ST: is_mem = 1'b1;
         OP_BEQZ:      take_br = (src_a == '0);
         OP_HALT:      is_halt = 1'b1;
         default:      illegal = 1'b1;
      endcase
      // Writes to r0 are dropped
      if (wr_idx == '0) begin
         wr_en = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         redir_q  <= 1'b0;
         cmd_q    <= 1'b0;
         halted   <= 1'b0;
         err      <= 1'b0;
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         wb_valid <= 1'b0;
         redir_q  <= 1'b0;
         if (accept) begin
            if (wr_en) begin
               regs[wr_idx] <= alu_res;
               wb_valid     <= 1'b1;
            end
            redir_q <= take_br;
            cmd_q   <= is_mem;
            if (is_halt || illegal) begin
               halted <= 1'b1;
            end
            if (illegal) begin
               err <= 1'b1;
            end
         end
         if (cmd_q && ls.done) begin
            cmd_q <= 1'b0;
            if (kind_q == MEM_READ && ld_rd != '0) begin
               regs[ld_rd] <= ls.rdata;
               wb_valid    <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         wb_reg     <= wr_idx;
         wb_data    <= alu_res;
         redir_pc_q <= br_target;
         kind_q     <= (ins.r.opcode == OP_ST) ? MEM_WRITE : MEM_READ;
         addr_q     <= ea[ADDR_W-1:0];
         wdata_q    <= st_data;
         ld_rd      <= ins.i.rd;
      end
      if (cmd_q && ls.done) begin
         wb_reg  <= ld_rd;
         wb_data <= ls.rdata;
      end
   end

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import mem_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   ls_if.lsu        ls,
   mem_if.requester mem
);

   // Low while requesting, high while a read is in flight
   logic waiting;

   assign mem.req   = ls.cmd_valid && !waiting;
   assign mem.kind  = ls.kind;
   assign mem.addr  = ls.addr;
   assign mem.wdata = ls.wdata;

   // Writes finish at the grant, reads when the data returns
   assign ls.done  = (!waiting && mem.gnt && ls.kind == MEM_WRITE) ||
                     (waiting && mem.rvalid);
   assign ls.rdata = mem.rdata;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         waiting <= 1'b0;
      end else if (!waiting) begin
         waiting <= mem.gnt && (ls.kind == MEM_READ);
      end else if (mem.rvalid) begin
         waiting <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== proc_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module proc_top import mem_pkg::*; (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          prog_en,
   input  logic [$clog2(`MEM_DEPTH)-1:0] prog_addr,
   input  logic [`DATA_W-1:0]            prog_data,
   input  logic                          start,
   output logic                          wb_valid,
   output logic [$clog2(`NUM_REGS)-1:0]  wb_reg,
   output logic [`DATA_W-1:0]            wb_data,
   output logic                          halted,
   output logic                          err
);

   mem_if   loader_bus ();
   mem_if   lsu_bus ();
   mem_if   fetch_bus ();
   fetch_if fe_bus ();
   ls_if    ls_bus ();

   logic                          mem_en;
   logic                          mem_we;
   logic [$clog2(`MEM_DEPTH)-1:0] mem_addr;
   logic [`DATA_W-1:0]            mem_wdata;
   logic [`DATA_W-1:0]            mem_rdata;

   // Program loading writes straight into memory at top priority
   assign loader_bus.req   = prog_en;
   assign loader_bus.kind  = MEM_WRITE;
   assign loader_bus.addr  = prog_addr;
   assign loader_bus.wdata = prog_data;

   fetch_unit u_fetch (.clk(clk), .rst_n(rst_n), .start(start), .mem(fetch_bus), .fe(fe_bus));

   exec_core u_core (
      .clk(clk), .rst_n(rst_n), .fe(fe_bus), .ls(ls_bus),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted), .err(err)
   );

   load_store_unit u_lsu (.clk(clk), .rst_n(rst_n), .ls(ls_bus), .mem(lsu_bus));

   mem_arbiter u_arb (
      .clk(clk), .rst_n(rst_n), .loader(loader_bus), .lsu(lsu_bus), .fetch(fetch_bus),
      .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata)
   );

   unified_mem u_mem (
      .clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
      .rdata(mem_rdata)
   );

endmodule

`default_nettype wire

// ==== tb_proc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module tb_proc import isa_pkg::*; ();

   localparam int NUM_TESTS = 6;
   localparam int ADDR_W    = $clog2(`MEM_DEPTH);

   logic                         clk;
   logic                         rst_n;
   logic                         prog_en;
   logic [ADDR_W-1:0]            prog_addr;
   logic [`DATA_W-1:0]           prog_data;
   logic                         start;
   logic                         wb_valid;
   logic [$clog2(`NUM_REGS)-1:0] wb_reg;
   logic [`DATA_W-1:0]           wb_data;
   logic                         halted;
   logic                         err;

   logic [`DATA_W-1:0] progs [NUM_TESTS][`MEM_DEPTH];
   int                 prog_len [NUM_TESTS];
   string              names [NUM_TESTS];
   int                 exp_reg [$];
   logic [`DATA_W-1:0] exp_data [$];
   logic               exp_err;
   string              cur_name;
   int                 errors;
   int                 n_pass;
   int                 n_fail;
   int                 seed;
   int                 build_idx;

   proc_top DUT (
      .clk(clk), .rst_n(rst_n), .prog_en(prog_en), .prog_addr(prog_addr),
      .prog_data(prog_data), .start(start), .wb_valid(wb_valid), .wb_reg(wb_reg),
      .wb_data(wb_data), .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Encoders follow the R and I field layouts
   function automatic logic [`DATA_W-1:0] r_word(opcode_e op, int rs, int rt, int rd);
      return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
   endfunction

   function automatic logic [`DATA_W-1:0] i_word(opcode_e op, int rs, int rd, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic void emit(input logic [`DATA_W-1:0] word);
      progs[build_idx][prog_len[build_idx]] = word;
      prog_len[build_idx]++;
   endfunction

   task automatic build_programs();
      int op_sel;
      int rnd;
      foreach (prog_len[t]) prog_len[t] = 0;
      build_idx = 0;
      names[0] = "alu";
      emit(i_word(OP_ADDI, 0, 1, 5));
      emit(i_word(OP_ADDI, 0, 2, -3));
      emit(r_word(OP_ADD, 1, 2, 3));
      emit(r_word(OP_SUB, 2, 1, 4));
      emit(r_word(OP_AND, 1, 2, 5));
      emit(r_word(OP_XOR, 1, 2, 6));
      emit(i_word(OP_ADDI, 6, 7, -16));
      emit(i_word(OP_ADDI, 1, 1, 15));
      emit(r_word(OP_HALT, 0, 0, 0));
      // Base address 120 keeps data clear of every program
      build_idx = 1;
      names[1] = "memory";
      emit(i_word(OP_ADDI, 0, 1, 15));
      emit(r_word(OP_ADD, 1, 1, 1));
      emit(r_word(OP_ADD, 1, 1, 1));
      emit(r_word(OP_ADD, 1, 1, 1));
      emit(i_word(OP_ADDI, 0, 2, 7));
      emit(i_word(OP_ADDI, 0, 3, -9));
      emit(i_word(OP_ST, 1, 2, 0));
      emit(i_word(OP_ST, 1, 3, 1));
      emit(i_word(OP_ST, 1, 1, -5));
      emit(i_word(OP_LD, 1, 4, 0));
      emit(i_word(OP_LD, 1, 5, 1));
      emit(i_word(OP_LD, 1, 6, -5));
      emit(r_word(OP_ADD, 6, 5, 7));
      emit(r_word(OP_HALT, 0, 0, 0));
      // Forward skip, a not-taken branch, then a countdown loop
      build_idx = 2;
      names[2] = "branch";
      emit(i_word(OP_ADDI, 0, 1, 3));
      emit(i_word(OP_BEQZ, 0, 0, 2));
      emit(i_word(OP_ADDI, 0, 2, 1));
      emit(i_word(OP_ADDI, 0, 3, 1));
      emit(i_word(OP_ADDI, 0, 4, 9));
      emit(i_word(OP_BEQZ, 1, 0, 1));
      emit(i_word(OP_ADDI, 0, 5, 4));
      emit(i_word(OP_ADDI, 1, 1, -1));
      emit(i_word(OP_BEQZ, 1, 0, 1));
      emit(i_word(OP_BEQZ, 0, 0, -3));
      emit(i_word(OP_ADDI, 4, 6, 1));
      emit(r_word(OP_HALT, 0, 0, 0));
      build_idx = 3;
      names[3] = "r0";
      emit(i_word(OP_ADDI, 0, 0, 7));
      emit(i_word(OP_ADDI, 0, 1, 5));
      emit(r_word(OP_ADD, 1, 1, 0));
      emit(r_word(OP_ADD, 0, 1, 2));
      emit(r_word(OP_XOR, 0, 0, 3));
      emit(r_word(OP_SUB, 0, 1, 4));
      emit(r_word(OP_HALT, 0, 0, 0));
      // Opcode 31 is outside the ISA
      build_idx = 4;
      names[4] = "illegal";
      emit(i_word(OP_ADDI, 0, 1, 2));
      emit(16'hf800);
      emit(i_word(OP_ADDI, 0, 2, 3));
      emit(r_word(OP_HALT, 0, 0, 0));
      build_idx = 5;
      names[5] = "random";
      for (int k = 0; k < 40; k++) begin
         op_sel = $unsigned($random(seed)) % 5;
         rnd    = $random(seed);
         case (op_sel)
            0:       emit(r_word(OP_ADD, rnd[10:8], rnd[7:5], rnd[4:2]));
            1:       emit(r_word(OP_SUB, rnd[10:8], rnd[7:5], rnd[4:2]));
            2:       emit(r_word(OP_AND, rnd[10:8], rnd[7:5], rnd[4:2]));
            3:       emit(r_word(OP_XOR, rnd[10:8], rnd[7:5], rnd[4:2]));
            default: emit(i_word(OP_ADDI, rnd[10:8], rnd[7:5], rnd[4:0]));
         endcase
      end
      emit(r_word(OP_HALT, 0, 0, 0));
   endtask

   // ISA model that fills the expected write queue and err
   function automatic void run_model(input int t, output int n_exec);
      logic [`DATA_W-1:0] m [`MEM_DEPTH];
      logic [`DATA_W-1:0] r [`NUM_REGS];
      logic [`DATA_W-1:0] w;
      logic [`DATA_W-1:0] a;
      logic [`DATA_W-1:0] b;
      logic [`DATA_W-1:0] imm;
      logic [`DATA_W-1:0] res;
      logic [ADDR_W-1:0]  pc;
      int                 dst;
      logic               wr;
      logic               stop;
      exp_reg.delete();
      exp_data.delete();
      exp_err = 1'b0;
      n_exec  = 0;
      pc      = '0;
      stop    = 1'b0;
      for (int i = 0; i < `MEM_DEPTH; i++) begin
         m[i] = (i < prog_len[t]) ? progs[t][i] : '0;
      end
      for (int i = 0; i < `NUM_REGS; i++) begin
         r[i] = '0;
      end
      while (!stop && n_exec < 1000) begin
         w   = m[pc];
         a   = r[w[10:8]];
         b   = r[w[7:5]];
         imm = {{(`DATA_W-5){w[4]}}, w[4:0]};
         dst = w[4:2];
         wr  = 1'b1;
         res = '0;
         n_exec++;
         pc  = pc + 1'b1;
         case (w[15:11])
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_AND: res = a & b;
            OP_XOR: res = a ^ b;
            OP_ADDI: begin
               res = a + imm;
               dst = w[7:5];
            end
            OP_LD: begin
               res = m[ADDR_W'(a + imm)];
               dst = w[7:5];
            end
            OP_ST: begin
               m[ADDR_W'(a + imm)] = r[w[7:5]];
               wr = 1'b0;
            end
            OP_BEQZ: begin
               if (a == '0) pc = pc + imm[ADDR_W-1:0];
               wr = 1'b0;
            end
            OP_HALT: begin
               stop = 1'b1;
               wr   = 1'b0;
            end
            default: begin
               stop    = 1'b1;
               exp_err = 1'b1;
               wr      = 1'b0;
            end
         endcase
         if (wr && dst != 0) begin
            r[dst] = res;
            exp_reg.push_back(dst);
            exp_data.push_back(res);
         end
      end
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
         errors++;
      end
   endtask

   // One expected write per trace entry
   always @(negedge clk) begin
      if (rst_n && wb_valid) begin
         if (exp_reg.size() == 0) begin
            $display("%s: unexpected register write r%0d = %0h", cur_name, wb_reg, wb_data);
            errors++;
         end else begin
            check_value("wb_reg", exp_reg.pop_front(), wb_reg);
            check_value("wb_data", exp_data.pop_front(), wb_data);
         end
      end
   end

   task automatic reset_dut();
      @(posedge clk);
      #1;
      rst_n   = 1'b0;
      prog_en = 1'b0;
      start   = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic load_program(input int t);
      for (int i = 0; i < prog_len[t]; i++) begin
         @(posedge clk);
         #1;
         prog_en   = 1'b1;
         prog_addr = ADDR_W'(i);
         prog_data = progs[t][i];
      end
      @(posedge clk);
      #1;
      prog_en = 1'b0;
   endtask

   task automatic run_test(input int t);
      int errs_before;
      int n_exec;
      cur_name = names[t];
      run_model(t, n_exec);
      errs_before = errors;
      reset_dut();
      load_program(t);
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      do @(negedge clk); while (!halted);
      // Let any late write show up
      repeat (3) @(negedge clk);
      if (exp_reg.size() != 0) begin
         $display("%s: %0d expected register writes never appeared", cur_name, exp_reg.size());
         errors++;
      end
      check_value("err", exp_err, err);
      if (errors == errs_before) begin
         $display("%s: ok, %0d instructions", cur_name, n_exec);
         n_pass++;
      end else begin
         $display("%s: %0d errors", cur_name, errors - errs_before);
         n_fail++;
      end
   endtask

   initial begin
      longint budget;
      int     n_exec;
      rst_n     = 1'b0;
      prog_en   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      start     = 1'b0;
      errors    = 0;
      n_pass    = 0;
      n_fail    = 0;
      seed      = 32'h2f98_a0f8;
      build_programs();
      budget = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_model(t, n_exec);
         budget += prog_len[t] + 6 * n_exec;
      end
      // Margin for reset, start and drain of each test
      budget = (budget + 40 * NUM_TESTS) * 100;
      fork
         begin
            #(budget);
            $display("Timeout: the DUT did not halt within %0d ns", budget);
            $display("Simulation FAILED");
            $finish;
         end
      join_none
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      $display("Tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
isa_pkg.sv
mem_pkg.sv
proc_ifs.sv
mem_arbiter.sv
unified_mem.sv
fetch_unit.sv
exec_core.sv
load_store_unit.sv
proc_top.sv
tb_proc.sv

// ==== Bender.yml ====
package:
  name: proc16

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - mem_pkg.sv
  - proc_ifs.sv
  - mem_arbiter.sv
  - unified_mem.sv
  - fetch_unit.sv
  - exec_core.sv
  - load_store_unit.sv
  - proc_top.sv
  - target: simulation
    files:
      - tb_proc.sv
